//--- flist.f
music_pkg.sv
player_pkg.sv
jukebox.sv
note_sequencer.sv
tone_generator.sv
melody_player.sv
tb_melody_player.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the melody player testbench with Verilator, runs it, checks for the pass line
set -u
cd "$(dirname "$0")" || exit 1

TOP=tb_melody_player
PASS_TEXT="all tests passed"

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

verilator --binary --timing --assert -Wno-fatal --top-module "$TOP" -f flist.f -o "sim_$TOP"
status=$?
if [ "$status" -ne 0 ]; then
    echo "build failed with status $status"
    exit 1
fi

output=$("./obj_dir/sim_$TOP" 2>&1)
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qxF "$PASS_TEXT"; then
    exit 0
fi
echo "pass line not found in simulation output"
exit 1

//--- tb_melody_player.sv
// ******************************
// testbench for the melody player, runs scale, silence and busy-start cases
// expected scores and half-periods are kept locally, checks are assertions
// ******************************
`timescale 1ns/1ps

module tb_melody_player;
    import music_pkg::*;

    localparam int BEAT       = 16;                 // clocks per beat
    localparam int NOTE_LIMIT = 15 * BEAT + 4;      // longest note plus slack
    localparam int RISE_LIMIT = 8;                  // bound on start to playing

    logic          clk;
    logic          rst_n;
    logic          start;
    logic [3:0]    melody_select;
    logic          speaker;
    logic          playing;
    logic          done;
    score_entry_t  current_note;

    logic [31:0]   rng_state;                       // xorshift state
    logic [7:0]    ref_notes [0:31];                // expected {tone, length}
    int            ref_count;
    int            first_total;                     // busy-start run length
    int            second_total;                    // back-to-back run length
    int            melody_total;                    // other runs

    // half-periods in clocks, do_ up to re_H
    logic [7:0] ref_half [0:14] = '{8'd60, 8'd57, 8'd53, 8'd50, 8'd48, 8'd45, 8'd42,
                                    8'd40, 8'd38, 8'd36, 8'd34, 8'd32, 8'd30, 8'd28, 8'd27};

    melody_player UUT (
        .clk           (clk),
        .rst_n         (rst_n),
        .start         (start),
        .melody_select (melody_select),
        .speaker       (speaker),
        .playing       (playing),
        .done          (done),
        .current_note  (current_note)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;                      // 8 ns period
    end

    // ******************************
    // reporting and helpers
    // ******************************
    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string test, input string what,
                                   input logic [31:0] exp, input logic [31:0] act);
        stop_on_error($sformatf("mismatch in %s, %s expected 0x%0h actual 0x%0h",
                                test, what, exp, act));
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // expected score lines, tone in the upper nibble
    task automatic load_reference(input logic [3:0] mel);
        ref_count = 0;
        case (mel)
            4'd2: begin
                ref_notes[0] = 8'h02;               // do_
                ref_notes[1] = 8'h22;               // re
                ref_notes[2] = 8'h42;               // mi
                ref_notes[3] = 8'h52;               // fa
                ref_notes[4] = 8'h72;               // sol
                ref_notes[5] = 8'h92;               // la
                ref_notes[6] = 8'hb2;               // si
                ref_notes[7] = 8'hc2;               // do_H
                ref_notes[8] = 8'he6;               // re_H, six beats
                ref_count    = 9;
            end
            4'd4: begin
                ref_notes[0] = 8'h02;
                ref_count    = 1;
            end
            4'd10: begin
                ref_notes[0] = 8'hf1;               // one silent beat
                ref_count    = 1;
            end
            default: stop_on_error("no reference score held for the requested melody");
        endcase
    endtask

    // outputs must stay quiet while idle
    task automatic idle_cycles(input string test, input int n);
        repeat (n) begin
            @(negedge clk);
            assert (!playing) else report_mismatch(test, "playing", 0, 32'(playing));
            assert (!done) else report_mismatch(test, "done", 0, 32'(done));
            assert (!speaker) else report_mismatch(test, "speaker", 0, 32'(speaker));
            assert (current_note == '0)
                else report_mismatch(test, "current_note", 0, 32'(current_note));
        end
    endtask

    task automatic idle_random_gap(input string test);
        rng_state = xorshift32(rng_state);
        idle_cycles(test, 1 + int'(rng_state[2:0]));
    endtask

    // ******************************
    // one note, bounded wait for its end
    // ******************************
    task automatic play_note(input string test, input logic [7:0] exp, input int busy_at,
                             inout int elapsed);
        int   held;
        int   half;
        logic want;
        held = 0;
        half = (exp[7:4] == 4'hf) ? 0 : int'(ref_half[exp[7:4]]);
        assert (current_note == exp)
            else report_mismatch(test, "note", 32'(exp), 32'(current_note));
        while (playing && current_note == exp && held < NOTE_LIMIT) begin
            if (half == 0) begin
                want = 1'b0;                        // silence stays low
            end else begin
                want = ((held / half) % 2) == 1;    // first toggle after one half-period
            end
            assert (speaker == want) else report_mismatch(test, "speaker", 32'(want),
                                                          32'(speaker));
            assert (!done) else report_mismatch(test, "done while playing", 0, 32'(done));
            start = (elapsed == busy_at);           // stray start while busy
            if (start) begin
                melody_select = 4'd2;               // must not be latched
            end
            held++;
            elapsed++;
            @(negedge clk);
        end
        start = 1'b0;
        assert (held < NOTE_LIMIT) else stop_on_error("a note never ended");
        assert (held == BEAT * int'(exp[3:0]))
            else report_mismatch(test, "note cycles", BEAT * int'(exp[3:0]), held);
    endtask

    task automatic run_melody(input string test, input logic [3:0] mel, input int busy_at,
                              output int total);
        int rise;
        load_reference(mel);
        start         = 1'b1;
        melody_select = mel;
        @(negedge clk);
        start         = 1'b0;
        rng_state     = xorshift32(rng_state);
        melody_select = rng_state[3:0];             // select already latched
        rise          = 1;
        while (!playing && rise < RISE_LIMIT) begin
            assert (!done) else report_mismatch(test, "done in fetch", 0, 32'(done));
            @(negedge clk);
            rise++;
        end
        assert (playing) else stop_on_error("playing never rose after start");
        assert (rise == 2) else report_mismatch(test, "start to playing cycles", 2, rise);
        total = 0;
        for (int i = 0; i < ref_count; i++) begin
            play_note(test, ref_notes[i], busy_at, total);
        end
        assert (!playing) else report_mismatch(test, "playing at end", 0, 32'(playing));
        assert (done) else report_mismatch(test, "done at end", 1, 32'(done));
        assert (current_note == '0)
            else report_mismatch(test, "current_note at end", 0, 32'(current_note));
    endtask

    // ******************************
    // protocol properties
    // ******************************
    assert property (@(posedge clk) disable iff (!rst_n) done |-> !playing)
        else stop_on_error("done pulsed while playing was still high");
    assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
        else stop_on_error("done stayed high for more than one cycle");
    assert property (@(posedge clk) disable iff (!rst_n) !playing |-> !speaker)
        else stop_on_error("speaker active while not playing");

    initial begin
        rng_state     = 32'h2a16d7bb;
        rst_n         = 1'b0;
        start         = 1'b0;
        melody_select = 4'd0;
        idle_cycles("reset", 3);                    // three clocks in reset
        rst_n = 1'b1;
        idle_cycles("after reset", 5);
        run_melody("scale", 4'd2, -1, melody_total);
        idle_random_gap("scale gap");
        run_melody("silence", 4'd10, -1, melody_total);
        idle_random_gap("silence gap");
        run_melody("busy start", 4'd4, 10, first_total);
        run_melody("back to back", 4'd4, -1, second_total);   // start in the done cycle
        assert (second_total == first_total)
            else report_mismatch("back to back", "melody cycles", first_total, second_total);
        idle_random_gap("final gap");
        $display("all tests passed");
        $finish;
    end

endmodule

//--- melody_player.sv
// ******************************
// melody player top, start pulse in, speaker out
// ******************************
`timescale 1ns/1ps

module melody_player (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               start,          // begin playback
    input  logic [music_pkg::MELODY_SEL_W-1:0] melody_select,  // which melody
    output logic                               speaker,
    output logic                               playing,
    output logic                               done,
    output music_pkg::score_entry_t            current_note    // for a display
);
    import music_pkg::*;

    logic [MELODY_SEL_W-1:0]   melody;              // latched select to ROM
    logic [NOTE_INDEX_W-1:0]   note_index;          // ROM address
    score_entry_t              entry;               // ROM data

    jukebox u_jukebox (
        .melody_select (melody),
        .note_index    (note_index),
        .entry         (entry)
    );

    note_sequencer u_note_sequencer (
        .clk           (clk),
        .rst_n         (rst_n),
        .start         (start),
        .melody_select (melody_select),
        .entry         (entry),
        .melody        (melody),
        .note_index    (note_index),
        .current_note  (current_note),
        .playing       (playing),
        .done          (done)
    );

    tone_generator u_tone_generator (
        .clk           (clk),
        .rst_n         (rst_n),
        .playing       (playing),
        .tone          (current_note.tone),
        .speaker       (speaker)
    );

endmodule

//--- tone_generator.sv
// ******************************
// square-wave tone from the current pitch
// muted on silence and while not playing
// ******************************
`timescale 1ns/1ps

module tone_generator (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    playing,
    input  music_pkg::music_note_t  tone,           // pitch of sounding note
    output logic                    speaker         // 1-bit audio out
);
    import music_pkg::*;

    music_note_t         tone_q;                    // pitch the divider runs on
    logic [HALF_W-1:0]   half;                      // half-period of tone
    logic [HALF_W-1:0]   cnt;                       // clocks since last toggle
    logic                spk_q;                     // square-wave level
    logic                active;                    // audible note
    logic                restart;                   // new note seen

    // ******************************
    // pitch lookup and control
    // ******************************
    always_comb begin
        half = '0;
        if (tone != silence) begin
            half = HALF_PERIOD[tone];               // table has no silence slot
        end
    end

    assign active  = playing && (tone != silence);
    assign restart = active && (tone != tone_q);    // first clock of a new pitch

    // ******************************
    // half-period divider
    // ******************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tone_q <= silence;
            cnt    <= '0;
            spk_q  <= 1'b0;
        end else if (!active) begin
            tone_q <= silence;                      // forces restart on next note
            cnt    <= '0;
            spk_q  <= 1'b0;
        end else if (restart) begin
            tone_q <= tone;
            cnt    <= HALF_W'(1);                   // note began one clock ago
            spk_q  <= 1'b0;
        end else if (cnt == half - 1'b1) begin
            cnt    <= '0;
            spk_q  <= ~spk_q;                       // toggle every half-period
        end else begin
            cnt    <= cnt + 1'b1;
        end
    end

    // level masked while muted or restarting
    assign speaker = active && !restart && spk_q;

endmodule

//--- note_sequencer.sv
// ******************************
// score walker FSM, times each note in beats
// drives the ROM address and registers the sounding note
// ******************************
`timescale 1ns/1ps

module note_sequencer (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               start,          // one-cycle pulse
    input  logic [music_pkg::MELODY_SEL_W-1:0] melody_select,  // raw select
    input  music_pkg::score_entry_t            entry,          // ROM line
    output logic [music_pkg::MELODY_SEL_W-1:0] melody,         // latched select
    output logic [music_pkg::NOTE_INDEX_W-1:0] note_index,     // ROM address
    output music_pkg::score_entry_t            current_note,   // sounding note
    output logic                               playing,
    output logic                               done            // end pulse
);
    import music_pkg::*;
    import player_pkg::*;

    player_state_t             state;
    logic [NOTE_INDEX_W-1:0]   idx;                 // index of sounding note
    logic [TICK_W-1:0]         tick_cnt;            // beat prescaler
    logic [DUR_W-1:0]          beats_left;          // beats still to play
    logic                      last_cycle;          // final clock of a note
    logic                      load;                // take entry this edge
    logic                      end_hit;             // melody over

    // ******************************
    // lookahead and end detection
    // ******************************
    assign last_cycle = (state == PLAY) && (tick_cnt == LAST_TICK)
                        && (beats_left == DUR_W'(1));
    assign load       = (state == FETCH) || last_cycle;   // fetch overlaps last clock
    assign note_index = last_cycle ? idx + 1'b1 : idx;    // peek next line early
    assign end_hit    = (entry.length == '0)
                        || (last_cycle && (idx == '1));    // terminator or slot 31

    // ******************************
    // FSM and counters
    // ******************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= IDLE;
            melody       <= '0;
            idx          <= '0;
            tick_cnt     <= '0;
            beats_left   <= '0;
            current_note <= '0;
            playing      <= 1'b0;
            done         <= 1'b0;
        end else begin
            done <= 1'b0;                           // pulse only
            case (state)
                IDLE: begin
                    if (start) begin
                        melody <= melody_select;    // hold for whole melody
                        idx    <= '0;
                        state  <= FETCH;
                    end
                end
                FETCH, PLAY: begin
                    if (load) begin
                        if (end_hit) begin
                            current_note <= '0;     // blank the display
                            playing      <= 1'b0;
                            done         <= 1'b1;   // same edge as playing falls
                            state        <= IDLE;
                        end else begin
                            current_note <= entry;
                            idx          <= note_index;
                            beats_left   <= DUR_W'(entry.length);
                            tick_cnt     <= '0;
                            playing      <= 1'b1;
                            state        <= PLAY;
                        end
                    end else begin
                        // only PLAY reaches here
                        if (tick_cnt == LAST_TICK) begin
                            tick_cnt   <= '0;
                            beats_left <= beats_left - 1'b1;   // beat boundary
                        end else begin
                            tick_cnt <= tick_cnt + 1'b1;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

//--- jukebox.sv
// ******************************
// melody ROM, 16 scores of up to 32 notes
// pure lookup by melody and note number
// ******************************
`timescale 1ns/1ps

module jukebox (
    input  logic [music_pkg::MELODY_SEL_W-1:0] melody_select,  // latched melody
    input  logic [music_pkg::NOTE_INDEX_W-1:0] note_index,     // note number
    output music_pkg::score_entry_t            entry           // tone and beats
);
    import music_pkg::*;

    score_entry_t score [MAX_NOTES];                // selected sheet

    // builds one score line
    function automatic score_entry_t nt(input music_note_t tone, input int beats);
        score_entry_t e;
        e.tone   = tone;
        e.length = LEN_W'(beats);                   // 1..15 beats
        return e;
    endfunction

    // ******************************
    // sheet music, unlisted slots are length 0
    // ******************************
    always_comb begin
        case (melody_select)
            4'd0: score = '{                        // children's song
                0: nt(sol, 2),   1: nt(mi, 2),   2: nt(mi, 4),     // first line
                3: nt(fa, 2),    4: nt(re, 2),   5: nt(re, 4),
                6: nt(do_, 2),   7: nt(re, 2),   8: nt(mi, 2),     // run up
                9: nt(fa, 2),   10: nt(sol, 2), 11: nt(sol, 2),
                12: nt(sol, 4),
                13: nt(sol, 2), 14: nt(mi, 2),  15: nt(mi, 4),     // second line
                16: nt(fa, 2),  17: nt(re, 2),  18: nt(re, 4),
                19: nt(do_, 2), 20: nt(mi, 2),  21: nt(sol, 2),    // closing
                22: nt(sol, 2), 23: nt(do_, 7),
                default: '0
            };
            4'd1: score = '{                        // symphony theme
                0: nt(mi, 2),   1: nt(mi, 2),   2: nt(fa, 2),      // phrase a
                3: nt(sol, 2),  4: nt(sol, 2),  5: nt(fa, 2),
                6: nt(mi, 2),   7: nt(re, 2),   8: nt(do_, 2),
                9: nt(do_, 2),  10: nt(re, 2),  11: nt(mi, 2),
                12: nt(mi, 4),  13: nt(re, 1),  14: nt(re, 5),     // half cadence
                15: nt(mi, 2),  16: nt(mi, 2),  17: nt(fa, 2),     // phrase b
                18: nt(sol, 2), 19: nt(sol, 2), 20: nt(fa, 2),
                21: nt(mi, 2),  22: nt(re, 2),  23: nt(do_, 2),
                24: nt(do_, 2), 25: nt(re, 2),  26: nt(mi, 2),
                27: nt(re, 4),  28: nt(do_, 1), 29: nt(do_, 5),    // full cadence
                default: '0
            };
            4'd2: score = '{                        // scale up
                0: nt(do_, 2),  1: nt(re, 2),   2: nt(mi, 2),
                3: nt(fa, 2),   4: nt(sol, 2),  5: nt(la, 2),
                6: nt(si, 2),   7: nt(do_H, 2), 8: nt(re_H, 6),    // long top note
                default: '0
            };
            4'd3: score = '{                        // scale down
                0: nt(re_H, 2), 1: nt(do_H, 2), 2: nt(si, 2),
                3: nt(la, 2),   4: nt(sol, 2),  5: nt(fa, 2),
                6: nt(mi, 2),   7: nt(re, 2),   8: nt(do_, 6),     // long bottom note
                default: '0
            };
            4'd4:  score = '{0: nt(do_, 2), default: '0};      // single notes
            4'd5:  score = '{0: nt(re, 2),  default: '0};
            4'd6:  score = '{0: nt(mi, 2),  default: '0};
            4'd7:  score = '{0: nt(fa, 2),  default: '0};
            4'd8:  score = '{0: nt(sol, 2), default: '0};
            4'd9:  score = '{0: nt(la, 2),  default: '0};
            4'd10: score = '{0: nt(silence, 1), default: '0};  // one quiet beat
            4'd11: score = '{                       // falling jingle
                0: nt(silence, 1), 1: nt(la, 1), 2: nt(fa, 1), 3: nt(re, 1),
                default: '0
            };
            4'd12: score = '{                       // falling jingle, long tail
                0: nt(silence, 1), 1: nt(do_H, 1), 2: nt(la, 1),
                3: nt(fa, 1),      4: nt(re, 1),   5: nt(do_, 2),
                6: nt(sol, 1),     7: nt(do_, 4),
                default: '0
            };
            4'd13: score = '{                       // power-up pickup
                0: nt(silence, 1), 1: nt(si, 1), 2: nt(re_H, 2),
                default: '0
            };
            4'd14: score = '{                       // jewel pickup
                0: nt(silence, 1), 1: nt(mi, 1), 2: nt(sol, 1), 3: nt(do_H, 2),
                default: '0
            };
            4'd15: score = '{                       // jewel pickup, long
                0: nt(silence, 1), 1: nt(do_, 1),  2: nt(mi, 1),
                3: nt(sol, 1),     4: nt(do_H, 2), 5: nt(sol, 1),
                6: nt(do_H, 2),
                default: '0
            };
            default: score = '{default: '0};        // never hit, all codes listed
        endcase
    end

    assign entry = score[note_index];               // read out current line

endmodule

//--- player_pkg.sv
// ******************************
// sequencer timing and state definitions
// real builds only retune BEAT_TICKS here
// ******************************
package player_pkg;

    // ******************************
    // sequencer FSM states
    // ******************************
    typedef enum logic [1:0] {
        IDLE,                                       // waiting for start
        FETCH,                                      // first note lookup
        PLAY                                        // note sounding
    } player_state_t;

    // ******************************
    // beat timing, sim scale
    // ******************************
    localparam int BEAT_TICKS = 16;                 // clocks per beat
    localparam int TICK_W     = $clog2(BEAT_TICKS); // prescaler width

    // prescaler wrap value, last clock of a beat
    localparam logic [TICK_W-1:0] LAST_TICK = TICK_W'(BEAT_TICKS - 1);

    // note duration counter, covers 15 beats of 16 clocks
    localparam int DUR_W = 8;

endpackage

//--- music_pkg.sv
// ******************************
// pitch and score definitions shared by the ROM, sequencer and tone path
// import with music_pkg::* inside the module body
// ******************************
package music_pkg;

    localparam int NOTE_INDEX_W = 5;                // note number width
    localparam int MAX_NOTES    = 2 ** NOTE_INDEX_W; // 32 entries per score
    localparam int MELODY_SEL_W = 4;                // 16 melodies
    localparam int LEN_W        = 4;                // length field, in beats
    localparam int HALF_W       = 8;                // half-period width, clocks

    // ******************************
    // pitch index, chromatic from do_ up to re_H
    // ******************************
    typedef enum logic [3:0] {
        do_, doD, re, reD, mi, fa, faD, sol,        // 0..7
        solD, la, laD, si, do_H, doDH, re_H,        // 8..e
        silence                                     // f, no sound
    } music_note_t;

    // one score line, length 0 ends the melody
    typedef struct packed {
        music_note_t        tone;                   // pitch
        logic [LEN_W-1:0]   length;                 // beats, 0 = end
    } score_entry_t;

    // ******************************
    // half-period per pitch in clocks, sim scale
    // ******************************
    // about one semitone step between entries
    localparam logic [HALF_W-1:0] HALF_PERIOD [0:14] = '{
        8'd60,                                      // do_
        8'd57,                                      // doD
        8'd53,                                      // re
        8'd50,                                      // reD
        8'd48,                                      // mi
        8'd45,                                      // fa
        8'd42,                                      // faD
        8'd40,                                      // sol
        8'd38,                                      // solD
        8'd36,                                      // la
        8'd34,                                      // laD
        8'd32,                                      // si
        8'd30,                                      // do_H
        8'd28,                                      // doDH
        8'd27                                       // re_H
    };

endpackage
